// ==== logic/snake_grid_pkg.sv ====
package snake_grid_pkg;

    //////////////////////////////////////////////////
    // grid geometry
    //////////////////////////////////////////////////

    // bits per coordinate, the grid is 32 by 32 cells
    localparam int COORD_W = 5;

    // last valid coordinate on either axis
    localparam int GRID_MAX = 31;

    // segments including the head
    localparam int MAX_LEN = 8;

    // head position after a start
    localparam int START_X = 16;
    localparam int START_Y = 16;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [COORD_W-1:0] coord_t;

    // y above x so the packed bits line up with the register layout
    typedef struct packed {
        coord_t y;
        coord_t x;
    } point_t;

    // segment count, 0 up to MAX_LEN
    typedef logic [3:0] len_t;

    // entry 0 is the head, higher entries trail behind it
    typedef point_t [MAX_LEN-1:0] seg_bus_t;

    // foods eaten, wraps
    typedef logic [7:0] score_t;

    // opposite directions differ only in bit 1
    typedef enum logic [1:0] {
        DIR_RIGHT = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_UP    = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DEAD = 2'd2
    } game_state_t;

endpackage

// ==== logic/snake_bus_pkg.sv ====
package snake_bus_pkg;

    //////////////////////////////////////////////////
    // wishbone widths and payloads
    //////////////////////////////////////////////////

    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 16;

    // word address
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // master to slave, 23 bits
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // slave to master, 17 bits
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////

    // bit 0 written high starts a game
    localparam wb_addr_t REG_CTRL   = 4'd0;
    localparam wb_addr_t REG_DIR    = 4'd1;
    localparam wb_addr_t REG_FOOD   = 4'd2;
    localparam wb_addr_t REG_STATUS = 4'd3;
    // segment words follow, one per entry
    localparam wb_addr_t REG_SEG0   = 4'd4;

endpackage

// ==== logic/snake_body.sv ====
`timescale 1ns/1ps

module snake_body (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     restart,
    input  logic                     step,
    input  logic                     grow,
    input  snake_grid_pkg::point_t   next_head,
    output snake_grid_pkg::seg_bus_t segs,
    output snake_grid_pkg::len_t     length
);
    import snake_grid_pkg::*;

    seg_bus_t seg_q;
    seg_bus_t seg_shift;
    len_t     len_q;
    len_t     len_next;
    point_t   start_pt;

    //////////////////////////////////////////////////
    // next length and shifted body
    //////////////////////////////////////////////////

    assign start_pt.x = coord_t'(START_X);
    assign start_pt.y = coord_t'(START_Y);

    always_comb begin
        len_next = len_q;
        // grow saturates, at full length it acts as a plain step
        if (grow && (len_q < MAX_LEN)) begin
            len_next = len_q + 1'b1;
        end
    end

    always_comb begin
        // new head enters at entry 0, old tail drops off the top
        seg_shift = {seg_q[MAX_LEN-2:0], next_head};
        // length mask
        // entries past the new length stay zero
        for (int i = 0; i < MAX_LEN; i++) begin
            if (i >= len_next) begin
                seg_shift[i] = '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // segment and length registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seg_q <= '0;
            len_q <= '0;
        end else if (restart) begin
            // fresh snake of one segment at the start cell
            seg_q    <= '0;
            seg_q[0] <= start_pt;
            len_q    <= len_t'(1);
        end else if (step || grow) begin
            seg_q <= seg_shift;
            len_q <= len_next;
        end
    end

    // segments hold still on dead or idle ticks
    // since neither step nor grow comes

    assign segs   = seg_q;
    assign length = len_q;

endmodule

// ==== logic/snake_collision.sv ====
`timescale 1ns/1ps

module snake_collision (
    input  snake_grid_pkg::seg_bus_t segs,
    input  snake_grid_pkg::len_t     length,
    input  snake_grid_pkg::dir_t     dir,
    input  snake_grid_pkg::point_t   food,
    output snake_grid_pkg::point_t   next_head,
    output logic                     hit_wall,
    output logic                     hit_self,
    output logic                     eat
);
    import snake_grid_pkg::*;

    point_t head;
    coord_t edge_hi;

    assign head    = segs[0];
    assign edge_hi = coord_t'(GRID_MAX);

    //////////////////////////////////////////////////
    // neighbour cell and wall test
    //////////////////////////////////////////////////

    always_comb begin
        next_head = head;
        hit_wall  = 1'b0;
        case (dir)
            DIR_RIGHT: begin
                next_head.x = head.x + 1'b1;
                hit_wall    = (head.x == edge_hi);
            end
            DIR_DOWN: begin
                next_head.y = head.y + 1'b1;
                hit_wall    = (head.y == edge_hi);
            end
            DIR_LEFT: begin
                next_head.x = head.x - 1'b1;
                hit_wall    = (head.x == '0);
            end
            default: begin
                // up, toward row 0
                next_head.y = head.y - 1'b1;
                hit_wall    = (head.y == '0);
            end
        endcase
    end

    // food straight ahead
    assign eat = (next_head == food);

    //////////////////////////////////////////////////
    // self hit
    //////////////////////////////////////////////////

    always_comb begin
        hit_self = 1'b0;
        // head itself never matches its neighbour
        for (int i = 1; i < MAX_LEN; i++) begin
            if ((i < length) && (segs[i] == next_head)) begin
                // a tail that moves on frees its cell
                if ((i + 1 != length) || eat) begin
                    hit_self = 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/snake_game_ctrl.sv ====
`timescale 1ns/1ps

module snake_game_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tick,
    input  logic                        start,
    input  snake_grid_pkg::dir_t        dir_req,
    input  logic                        dir_wr,
    input  logic                        hit_wall,
    input  logic                        hit_self,
    input  logic                        eat,
    output snake_grid_pkg::game_state_t state,
    output snake_grid_pkg::dir_t        dir,
    output snake_grid_pkg::score_t      score,
    output logic                        restart,
    output logic                        step,
    output logic                        grow
);
    import snake_grid_pkg::*;

    game_state_t state_q;
    dir_t        dir_q;
    score_t      score_q;

    logic hit;
    logic run_tick;
    logic reverse;

    assign hit      = hit_wall || hit_self;
    // start wins over a tick in the same cycle
    assign run_tick = tick && (state_q == ST_RUN) && !start;
    // opposite of the current heading
    assign reverse  = (dir_req == dir_t'(dir_q ^ 2'b10));

    //////////////////////////////////////////////////
    // pulses to the body
    //////////////////////////////////////////////////

    // body acts on the same edge as the tick
    assign restart = start;
    assign grow    = run_tick && !hit && eat;
    assign step    = run_tick && !hit && !eat;

    //////////////////////////////////////////////////
    // state machine, heading and score
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            dir_q   <= DIR_RIGHT;
            score_q <= '0;
        end else if (start) begin
            // new game from any state
            state_q <= ST_RUN;
            dir_q   <= DIR_RIGHT;
            score_q <= '0;
        end else begin
            if (run_tick) begin
                if (hit) begin
                    state_q <= ST_DEAD;
                end else if (eat) begin
                    // counts even when length is already full
                    score_q <= score_q + 1'b1;
                end
            end
            // u-turns are dropped
            if (dir_wr && !reverse) begin
                dir_q <= dir_req;
            end
        end
    end

    assign state = state_q;
    assign dir   = dir_q;
    assign score = score_q;

endmodule

// ==== logic/snake_wb_regs.sv ====
`timescale 1ns/1ps

module snake_wb_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  snake_bus_pkg::wb_req_t      wb_req,
    output snake_bus_pkg::wb_rsp_t      wb_rsp,
    input  snake_grid_pkg::game_state_t state,
    input  snake_grid_pkg::dir_t        dir,
    input  snake_grid_pkg::len_t        length,
    input  snake_grid_pkg::score_t      score,
    input  snake_grid_pkg::seg_bus_t    segs,
    output logic                        start,
    output snake_grid_pkg::dir_t        dir_req,
    output logic                        dir_wr,
    output snake_grid_pkg::point_t      food
);
    import snake_grid_pkg::*;
    import snake_bus_pkg::*;

    logic     ack_q;
    wb_data_t rdat_q;
    wb_data_t rdat_mux;
    point_t   food_q;

    logic     access;
    logic     wr;
    wb_addr_t seg_off;
    logic     seg_hit;
    point_t   seg_pt;

    //////////////////////////////////////////////////
    // classic handshake
    //////////////////////////////////////////////////

    // new cycle seen while ack is low
    // ack drops after one cycle so the held request is not taken twice
    assign access = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr     = access && wb_req.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    //////////////////////////////////////////////////
    // writes
    //////////////////////////////////////////////////

    // pulses land on the ack edge in the controller
    assign start   = wr && (wb_req.adr == REG_CTRL) && wb_req.dat[0];
    assign dir_wr  = wr && (wb_req.adr == REG_DIR);
    assign dir_req = dir_t'(wb_req.dat[1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            food_q <= '0;
        end else if (wr && (wb_req.adr == REG_FOOD)) begin
            food_q <= point_t'(wb_req.dat[9:0]);
        end
    end

    assign food = food_q;

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////

    // segment words sit at 4 through 11
    assign seg_off = wb_req.adr - REG_SEG0;
    assign seg_hit = (wb_req.adr >= REG_SEG0) && (seg_off < MAX_LEN);
    assign seg_pt  = segs[seg_off[2:0]];

    always_comb begin
        rdat_mux = '0;
        if (seg_hit) begin
            // inactive entries read zero
            if (seg_off < length) begin
                rdat_mux = wb_data_t'(seg_pt);
            end
        end else begin
            case (wb_req.adr)
                REG_DIR:    rdat_mux = wb_data_t'(dir);
                REG_FOOD:   rdat_mux = wb_data_t'(food_q);
                REG_STATUS: rdat_mux = {score, 2'b00, length, state};
                // ctrl and unmapped words read zero
                default:    rdat_mux = '0;
            endcase
        end
    end

    // sampled with the access so data is valid with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= rdat_mux;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

endmodule

// ==== logic/snake_top.sv ====
`timescale 1ns/1ps

module snake_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tick,
    input  snake_bus_pkg::wb_req_t wb_req,
    output snake_bus_pkg::wb_rsp_t wb_rsp
);
    import snake_grid_pkg::*;

    // bus side
    logic        start;
    dir_t        dir_req;
    logic        dir_wr;
    point_t      food;

    // controller outputs
    game_state_t state;
    dir_t        dir;
    score_t      score;
    logic        restart;
    logic        step;
    logic        grow;

    // body and collision
    seg_bus_t    segs;
    len_t        length;
    point_t      next_head;
    logic        hit_wall;
    logic        hit_self;
    logic        eat;

    //////////////////////////////////////////////////
    // register slave
    //////////////////////////////////////////////////

    snake_wb_regs u_wb_regs (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .state   (state),
        .dir     (dir),
        .length  (length),
        .score   (score),
        .segs    (segs),
        .start   (start),
        .dir_req (dir_req),
        .dir_wr  (dir_wr),
        .food    (food)
    );

    //////////////////////////////////////////////////
    // game core
    //////////////////////////////////////////////////

    snake_game_ctrl u_game_ctrl (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .start    (start),
        .dir_req  (dir_req),
        .dir_wr   (dir_wr),
        .hit_wall (hit_wall),
        .hit_self (hit_self),
        .eat      (eat),
        .state    (state),
        .dir      (dir),
        .score    (score),
        .restart  (restart),
        .step     (step),
        .grow     (grow)
    );

    // combinational, same cycle as the tick
    snake_collision u_collision (
        .segs      (segs),
        .length    (length),
        .dir       (dir),
        .food      (food),
        .next_head (next_head),
        .hit_wall  (hit_wall),
        .hit_self  (hit_self),
        .eat       (eat)
    );

    snake_body u_body (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .step      (step),
        .grow      (grow),
        .next_head (next_head),
        .segs      (segs),
        .length    (length)
    );

endmodule

// ==== test/snake_asserts.sv ====
`timescale 1ns/1ps

module snake_asserts (
    input logic                        clk,
    input logic                        rst,
    input snake_bus_pkg::wb_req_t      wb_req,
    input snake_bus_pkg::wb_rsp_t      wb_rsp,
    input snake_grid_pkg::game_state_t state,
    input snake_grid_pkg::len_t        length,
    input logic                        step,
    input logic                        grow
);
    import snake_grid_pkg::*;

    // tally of failed properties
    int fail_count = 0;

    //////////////////////////////////////////////////
    // bus handshake
    //////////////////////////////////////////////////

    // ack is a one cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_count++;
            $error("ack high for two cycles in a row");
        end

    // only inside an active cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fail_count++;
            $error("ack without cyc and stb");
        end

    //////////////////////////////////////////////////
    // game invariants
    //////////////////////////////////////////////////

    len_limit: assert property (@(posedge clk) disable iff (rst)
        length <= len_t'(MAX_LEN))
        else begin
            fail_count++;
            $error("length above the segment limit");
        end

    // body moves only in a running game
    move_in_run: assert property (@(posedge clk) disable iff (rst)
        (step || grow) |-> (state == ST_RUN))
        else begin
            fail_count++;
            $error("step or grow outside the run state");
        end

endmodule

bind snake_top snake_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .state  (state),
    .length (length),
    .step   (step),
    .grow   (grow)
);

// ==== test/snake_tb.sv ====
`timescale 1ns/1ps

module snake_tb;
    import snake_grid_pkg::*;
    import snake_bus_pkg::*;

    // tests need a bit under 1000 cycles, about three times that is allowed
    localparam int TIMEOUT_CYCLES = 3000;

    // food parked away from every path the tests take
    localparam int PARK_X = 1;
    localparam int PARK_Y = 30;

    logic    clk;
    logic    rst;
    logic    tick;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int    cycles = 0;
    string test_name;

    // reference model, state 0 idle, 1 run, 2 dead
    int mx [MAX_LEN];
    int my [MAX_LEN];
    int mlen;
    int mdir;
    int mscore;
    int mstate;
    int fx;
    int fy;

    snake_top u_snake_top (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    //////////////////////////////////////////////////
    // clock and run limit
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Test failed");
            $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // bound checker counts its failed properties
    always @(posedge clk) begin
        if (u_snake_top.u_asserts.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

    task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s: %s expected 0x%04h, actual 0x%04h",
                     test_name, what, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    //////////////////////////////////////////////////
    // bus and tick drivers
    //////////////////////////////////////////////////

    task automatic wb_access(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                             output wb_data_t rdat);
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(posedge clk);
        #1;
        // request held until ack shows
        while (!wb_rsp.ack) begin
            @(posedge clk);
            #1;
        end
        rdat = wb_rsp.dat;
        // ack sampled on the next edge, then released
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        wb_access(adr, 1'b1, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        wb_access(adr, 1'b0, '0, dat);
    endtask

    task automatic do_tick();
        @(posedge clk);
        #1;
        tick = 1'b1;
        @(posedge clk);
        #1;
        tick = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // game model
    //////////////////////////////////////////////////

    task automatic model_clear();
        for (int i = 0; i < MAX_LEN; i++) begin
            mx[i] = 0;
            my[i] = 0;
        end
    endtask

    task automatic model_tick();
        int nx;
        int ny;
        bit wall;
        bit self_hit;
        bit eats;
        if (mstate == 1) begin
            nx   = mx[0];
            ny   = my[0];
            wall = 1'b0;
            case (mdir)
                0: begin
                    wall = (nx == GRID_MAX);
                    nx   = nx + 1;
                end
                1: begin
                    wall = (ny == GRID_MAX);
                    ny   = ny + 1;
                end
                2: begin
                    wall = (nx == 0);
                    nx   = nx - 1;
                end
                default: begin
                    wall = (ny == 0);
                    ny   = ny - 1;
                end
            endcase
            eats     = (nx == fx) && (ny == fy);
            self_hit = 1'b0;
            for (int i = 1; i < mlen; i++) begin
                // tail cell is free unless the snake grows
                if ((mx[i] == nx) && (my[i] == ny) && ((i != mlen - 1) || eats)) begin
                    self_hit = 1'b1;
                end
            end
            if (wall || self_hit) begin
                mstate = 2;
            end else begin
                if (eats) begin
                    mscore = (mscore + 1) % 256;
                end
                if (eats && (mlen < MAX_LEN)) begin
                    mlen++;
                end
                for (int i = MAX_LEN - 1; i > 0; i--) begin
                    mx[i] = (i < mlen) ? mx[i-1] : 0;
                    my[i] = (i < mlen) ? my[i-1] : 0;
                end
                mx[0] = nx;
                my[0] = ny;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // game actions, each on DUT and model
    //////////////////////////////////////////////////

    task automatic start_game();
        wb_write(REG_CTRL, 16'h0001);
        model_clear();
        mx[0]  = START_X;
        my[0]  = START_Y;
        mlen   = 1;
        mdir   = 0;
        mscore = 0;
        mstate = 1;
    endtask

    task automatic steer(input dir_t d);
        wb_write(REG_DIR, wb_data_t'(d));
        // u-turn requests leave the heading alone
        if ((int'(d) ^ 2) != mdir) begin
            mdir = int'(d);
        end
    endtask

    task automatic place_food(input int x, input int y);
        wb_write(REG_FOOD, wb_data_t'((y << 5) | x));
        fx = x;
        fy = y;
    endtask

    task automatic move();
        do_tick();
        model_tick();
    endtask

    // eat n foods heading right
    task automatic grow_right(input int n);
        for (int k = 0; k < n; k++) begin
            place_food(mx[0] + 1, my[0]);
            move();
        end
        place_food(PARK_X, PARK_Y);
    endtask

    task automatic check_status();
        wb_data_t rd;
        wb_read(REG_STATUS, rd);
        check("STATUS", wb_data_t'((mscore << 8) | (mlen << 2) | mstate), rd);
    endtask

    task automatic check_all();
        wb_data_t rd;
        wb_data_t exp;
        check_status();
        wb_read(REG_DIR, rd);
        check("DIR", wb_data_t'(mdir), rd);
        for (int i = 0; i < MAX_LEN; i++) begin
            wb_read(wb_addr_t'(REG_SEG0 + i), rd);
            exp = (i < mlen) ? wb_data_t'((my[i] << 5) | mx[i]) : '0;
            check($sformatf("SEG%0d", i), exp, rd);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_start();
        test_name = "reset_start";
        check_all();
        // food beside the empty head so a stray idle tick would eat it
        place_food(1, 0);
        move();
        check_all();
        start_game();
        check_all();
    endtask

    task automatic test_moves();
        test_name = "moves";
        start_game();
        place_food(PARK_X, PARK_Y);
        move();
        check_all();
        steer(DIR_DOWN);
        move();
        check_all();
        steer(DIR_LEFT);
        move();
        check_all();
        steer(DIR_UP);
        move();
        check_all();
        // down is a u-turn while heading up
        steer(DIR_DOWN);
        check_all();
        move();
        check_all();
    endtask

    task automatic test_grow();
        test_name = "grow";
        start_game();
        for (int n = 0; n < 9; n++) begin
            place_food(mx[0] + 1, my[0]);
            move();
            // full length after 7 foods, then score only
            if ((n == 6) || (n == 8)) begin
                check_all();
            end else begin
                check_status();
            end
        end
    endtask

    task automatic test_wall();
        test_name = "wall";
        start_game();
        place_food(PARK_X, PARK_Y);
        repeat (15) move();
        // head on the last column, still alive
        check_all();
        move();
        check_all();
        // open heading in the dead state, body still frozen
        steer(DIR_DOWN);
        move();
        move();
        check_all();
    endtask

    task automatic test_self_hit();
        test_name = "self_hit";
        start_game();
        grow_right(4);
        check_all();
        steer(DIR_DOWN);
        move();
        steer(DIR_LEFT);
        move();
        steer(DIR_UP);
        move();
        check_all();
        // length 2 turning back onto the cell its tail leaves
        start_game();
        grow_right(1);
        steer(DIR_DOWN);
        steer(DIR_LEFT);
        move();
        check_all();
    endtask

    task automatic test_restart();
        test_name = "restart";
        start_game();
        steer(DIR_UP);
        place_food(START_X, START_Y - 1);
        move();
        place_food(PARK_X, PARK_Y);
        // climb into the top wall
        while (mstate == 1) begin
            move();
        end
        check_all();
        start_game();
        check_all();
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rst    = 1'b1;
        tick   = 1'b0;
        wb_req = '0;
        model_clear();
        mlen   = 0;
        mdir   = 0;
        mscore = 0;
        mstate = 0;
        fx     = 0;
        fy     = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_start();
        test_moves();
        test_grow();
        test_wall();
        test_self_hit();
        test_restart();

        if (u_snake_top.u_asserts.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/snake_grid_pkg.sv
logic/snake_bus_pkg.sv
logic/snake_body.sv
logic/snake_collision.sv
logic/snake_game_ctrl.sv
logic/snake_wb_regs.sv
logic/snake_top.sv
test/snake_asserts.sv
test/snake_tb.sv
